//--- exec.sv
module exec import riscv_pkg::*; (
    input  decode_ctrl_t    ctrl,
    input  decode_data_t    data,
    input  exec_data_t      mem_stage,
    input  wb_t             wb,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    output exec_data_t      out,
    output logic [xlen-1:0] data_addr,
    output logic [xlen-1:0] din,
    output logic            pc_src,
    output logic [xlen-1:0] pc_target
);
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] fwd_b_val;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;
    logic            equal;

    function automatic logic [xlen-1:0] pick(input fwd_sel_e sel,
                                             input logic [xlen-1:0] reg_val,
                                             input logic [xlen-1:0] mem_val,
                                             input logic [xlen-1:0] wb_val);
        case (sel)
            fwd_mem: pick = mem_val;
            fwd_wb:  pick = wb_val;
            default: pick = reg_val;
        endcase
    endfunction

    assign src_a     = pick(fwd_a, data.rd1, mem_stage.alu_result, wb.result);
    assign fwd_b_val = pick(fwd_b, data.rd2, mem_stage.alu_result, wb.result);
    assign src_b     = ctrl.alu_src ? data.imm_ext : fwd_b_val;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:    alu_result = src_a - src_b;
            alu_and:    alu_result = src_a & src_b;
            alu_or:     alu_result = src_a | src_b;
            alu_xor:    alu_result = src_a ^ src_b;
            alu_slt:    alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            alu_pass_b: alu_result = src_b;
            default:    alu_result = src_a + src_b;
        endcase
    end

    // branch compares the two register operands
    assign equal     = (src_a == fwd_b_val);
    assign pc_src    = ctrl.jump | (ctrl.branch & (equal ^ ctrl.branch_ne));
    assign pc_target = data.pc + data.imm_ext;

    assign data_addr = alu_result;
    assign din       = fwd_b_val;

    assign out.reg_write  = ctrl.reg_write;
    assign out.result_src = ctrl.result_src;
    assign out.alu_result = alu_result;
    assign out.rd         = data.rd;
    assign out.imm_ext    = data.imm_ext;
    assign out.pc_plus4   = data.pc_plus4;

endmodule

//--- hazard_unit.sv
module hazard_unit import riscv_pkg::*; (
    input  logic [reg_addr_w-1:0] rs1_d,
    input  logic [reg_addr_w-1:0] rs2_d,
    input  logic [reg_addr_w-1:0] rs1_e,
    input  logic [reg_addr_w-1:0] rs2_e,
    input  logic [reg_addr_w-1:0] rd_e,
    input  logic                  mem_read_e,
    input  logic                  pc_src,
    input  exec_data_t            mem_stage,
    input  wb_t                   wb,
    output fwd_sel_e              fwd_a,
    output fwd_sel_e              fwd_b,
    output logic                  stall_f,
    output logic                  stall_d,
    output logic                  flush_d,
    output logic                  flush_e
);
    logic load_use;

    function automatic fwd_sel_e fwd_for(input logic [reg_addr_w-1:0] rs,
                                         input exec_data_t mem_in,
                                         input wb_t wb_in);
        if (mem_in.reg_write && mem_in.rd != '0 && mem_in.rd == rs) begin
            fwd_for = fwd_mem;
        end else if (wb_in.reg_write && wb_in.rd != '0 && wb_in.rd == rs) begin
            fwd_for = fwd_wb;
        end else begin
            fwd_for = fwd_reg;
        end
    endfunction

    assign fwd_a = fwd_for(rs1_e, mem_stage, wb);
    assign fwd_b = fwd_for(rs2_e, mem_stage, wb);

    // load in E feeding the instruction in D
    assign load_use = mem_read_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

    assign stall_f = load_use;
    assign stall_d = load_use;
    assign flush_d = pc_src;
    assign flush_e = load_use | pc_src;

endmodule

//--- instr_decode.sv
module instr_decode import riscv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  fetch_data_t  fetch,
    input  wb_t          wb,
    output decode_ctrl_t ctrl,
    output decode_data_t data
);
    logic [xlen-1:0]       rf [32];
    logic [xlen-1:0]       instr;
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  funct7_5;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm_ext;

    assign instr    = fetch.instr;
    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];

    always_comb begin
        ctrl    = '0;
        imm_ext = '0;
        case (opcode)
            opc_op: begin
                ctrl.reg_write = 1'b1;
                unique case (funct3)
                    3'b000:  ctrl.alu_op = funct7_5 ? alu_sub : alu_add;
                    3'b111:  ctrl.alu_op = alu_and;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b010:  ctrl.alu_op = alu_slt;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            opc_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm_ext        = {{20{instr[31]}}, instr[31:20]};
                unique case (funct3)
                    3'b000:  ctrl.alu_op = alu_add;
                    3'b111:  ctrl.alu_op = alu_and;
                    3'b110:  ctrl.alu_op = alu_or;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            opc_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = res_mem;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                imm_ext         = {{20{instr[31]}}, instr[31:20]};
            end
            opc_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm_ext        = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opc_branch: begin
                // only beq and bne
                ctrl.branch    = (funct3[2:1] == 2'b00);
                ctrl.branch_ne = funct3[0];
                ctrl.alu_op    = alu_sub;
                imm_ext        = {{19{instr[31]}}, instr[31], instr[7],
                                  instr[30:25], instr[11:8], 1'b0};
            end
            opc_jal: begin
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.result_src = res_pc_plus4;
                imm_ext         = {{11{instr[31]}}, instr[31], instr[19:12],
                                   instr[20], instr[30:21], 1'b0};
            end
            opc_lui: begin
                // alu passes the immediate so the M stage can forward it
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = res_imm;
                ctrl.alu_op     = alu_pass_b;
                ctrl.alu_src    = 1'b1;
                imm_ext         = {instr[31:12], 12'b0};
            end
            default: ctrl = '0;
        endcase
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            rf[wb.rd] <= wb.result;
        end
    end

    // same-cycle write returns the new value
    assign data.rd1 = (wb.reg_write && wb.rd != '0 && wb.rd == rs1) ? wb.result : rf[rs1];
    assign data.rd2 = (wb.reg_write && wb.rd != '0 && wb.rd == rs2) ? wb.result : rf[rs2];

    assign data.pc       = fetch.pc;
    assign data.rs1      = rs1;
    assign data.rs2      = rs2;
    assign data.rd       = instr[11:7];
    assign data.imm_ext  = imm_ext;
    assign data.pc_plus4 = fetch.pc_plus4;

endmodule

//--- instr_fetch.sv
module instr_fetch import riscv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            pc_src,
    input  logic [xlen-1:0] pc_target,
    output logic [xlen-1:0] pc,
    output fetch_data_t     fetch,
    input  logic [xlen-1:0] instr
);
    logic [xlen-1:0] pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // redirect has priority over a load-use stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_src) begin
            pc <= pc_target;
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    assign fetch.pc       = pc;
    assign fetch.instr    = instr;
    assign fetch.pc_plus4 = pc_plus4;

endmodule

//--- memory_access.sv
module memory_access import riscv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  exec_data_t      in,
    input  logic [xlen-1:0] read_data,
    output wb_t             wb
);
    logic [xlen-1:0] result;

    // read_data belongs to the load now in this stage
    always_comb begin
        case (in.result_src)
            res_mem:      result = read_data;
            res_pc_plus4: result = in.pc_plus4;
            res_imm:      result = in.imm_ext;
            default:      result = in.alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb.reg_write <= in.reg_write;
            wb.rd        <= in.rd;
            wb.result    <= result;
        end
    end

endmodule

//--- riscv_pipeline.f
riscv_pkg.sv
instr_fetch.sv
instr_decode.sv
exec.sv
memory_access.sv
hazard_unit.sv
riscv_pipeline.sv
tb_checker.sv
tb_riscv_pipeline.sv

//--- riscv_pipeline.sv
module riscv_pipeline import riscv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] pc,
    output logic            en_instr_mem,
    input  logic [xlen-1:0] read_data,
    output logic            data_we,
    output logic            data_re,
    output logic [xlen-1:0] data_addr,
    output logic [xlen-1:0] din
);
    fetch_data_t     fetch_f;
    fetch_data_t     fetch_d;
    decode_ctrl_t    ctrl_d;
    decode_data_t    data_d;
    decode_ctrl_t    ctrl_e;
    decode_data_t    data_e;
    exec_data_t      exec_e;
    exec_data_t      exec_m;
    wb_t             wb;
    logic            pc_src;
    logic [xlen-1:0] pc_target;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic            stall_f;
    logic            stall_d;
    logic            flush_d;
    logic            flush_e;

    instr_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall_f),
        .pc_src    (pc_src),
        .pc_target (pc_target),
        .pc        (pc),
        .fetch     (fetch_f),
        .instr     (instr)
    );

    // an all-zero word in IF/ID decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            fetch_d <= '0;
        end else if (!stall_d) begin
            fetch_d <= fetch_f;
        end
    end

    instr_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .fetch (fetch_d),
        .wb    (wb),
        .ctrl  (ctrl_d),
        .data  (data_d)
    );

    // ID/EX
    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            ctrl_e <= '0;
        end else begin
            ctrl_e <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        data_e <= data_d;
    end

    exec u_exec (
        .ctrl      (ctrl_e),
        .data      (data_e),
        .mem_stage (exec_m),
        .wb        (wb),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .out       (exec_e),
        .data_addr (data_addr),
        .din       (din),
        .pc_src    (pc_src),
        .pc_target (pc_target)
    );

    // data memory samples these at the next edge
    assign data_we = ctrl_e.mem_write;
    assign data_re = ctrl_e.mem_read;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_m <= '0;
        end else begin
            exec_m <= exec_e;
        end
    end

    memory_access u_mem (
        .clk       (clk),
        .rst       (rst),
        .in        (exec_m),
        .read_data (read_data),
        .wb        (wb)
    );

    hazard_unit u_hazard (
        .rs1_d      (data_d.rs1),
        .rs2_d      (data_d.rs2),
        .rs1_e      (data_e.rs1),
        .rs2_e      (data_e.rs2),
        .rd_e       (data_e.rd),
        .mem_read_e (ctrl_e.mem_read),
        .pc_src     (pc_src),
        .mem_stage  (exec_m),
        .wb         (wb),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .stall_f    (stall_f),
        .stall_d    (stall_d),
        .flush_d    (flush_d),
        .flush_e    (flush_e)
    );

    assign en_instr_mem = ~stall_d;

endmodule

//--- riscv_pkg.sv
package riscv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc_plus4,
        res_imm
    } result_src_e;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_wb,
        fwd_mem
    } fwd_sel_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc_plus4;
    } fetch_data_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_read;
        logic        mem_write;
        logic        jump;
        logic        branch;
        logic        branch_ne;
        alu_op_e     alu_op;
        logic        alu_src;
    } decode_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]       rd1;
        logic [xlen-1:0]       rd2;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm_ext;
        logic [xlen-1:0]       pc_plus4;
    } decode_data_t;

    typedef struct packed {
        logic                  reg_write;
        result_src_e           result_src;
        logic [xlen-1:0]       alu_result;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm_ext;
        logic [xlen-1:0]       pc_plus4;
    } exec_data_t;

    typedef struct packed {
        logic                  reg_write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } wb_t;

endpackage

//--- tb_checker.sv
module tb_checker (
    input logic        clk,
    input logic        data_we,
    input logic [31:0] data_addr,
    input logic [31:0] din,
    input logic [31:0] prog [256],
    input logic [31:0] mem_init [256]
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    store_t exp_q [$];
    store_t expected;
    string  test_name;
    bit     active = 1'b0;
    int     errors = 0;
    int     checked = 0;

    // architectural model that runs until the store to 0x3fc
    function automatic void run_reference();
        logic [31:0] x [32];
        logic [31:0] m [256];
        logic [31:0] pc, npc, ins, a, b, res, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic        wr;
        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            m[i] = mem_init[i];
        end
        pc = '0;
        for (int step = 0; step < 2000; step++) begin
            ins   = prog[pc[9:2]];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc   = pc + 32'd4;
            wr    = 1'b0;
            res   = '0;
            case (ins[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'd0:    res = ins[30] ? a - b : a + b;
                        3'd2:    res = {31'b0, $signed(a) < $signed(b)};
                        3'd4:    res = a ^ b;
                        3'd6:    res = a | b;
                        3'd7:    res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'h13: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'd0:    res = a + imm_i;
                        3'd6:    res = a | imm_i;
                        3'd7:    res = a & imm_i;
                        default: wr = 1'b0;
                    endcase
                end
                7'h03: begin
                    addr = a + imm_i;
                    wr   = 1'b1;
                    res  = m[addr[9:2]];
                end
                7'h23: begin
                    addr = a + imm_s;
                    exp_q.push_back({addr, b});
                    m[addr[9:2]] = b;
                    if (addr == 32'h0000_03FC) begin
                        return;
                    end
                end
                // funct3 bit 0 turns beq into bne
                7'h63: begin
                    if ((a == b) != ins[12]) begin
                        npc = pc + imm_b;
                    end
                end
                7'h6F: begin
                    wr  = 1'b1;
                    res = pc + 32'd4;
                    npc = pc + imm_j;
                end
                7'h37: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'b0};
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            pc = npc;
        end
        $display("reference model of %s never reached the halt store", test_name);
        errors++;
    endfunction

    task automatic start_program(input string name);
        test_name = name;
        run_reference();
        active = 1'b1;
    endtask

    task automatic end_program();
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected stores never showed up at the data port",
                     test_name, exp_q.size());
            errors++;
        end
        active = 1'b0;
    endtask

    // store outputs are settled by the falling edge
    always @(negedge clk) begin
        if (active && data_we) begin
            if (exp_q.size() == 0) begin
                $display("%s: extra store of %h to address %h", test_name, din, data_addr);
                errors++;
            end else begin
                expected = exp_q.pop_front();
                if (expected.addr !== data_addr || expected.data !== din) begin
                    $display("ERR %s: store %0d expected [%h] = %h, actual [%h] = %h",
                             test_name, checked, expected.addr, expected.data,
                             data_addr, din);
                    errors++;
                end
                checked++;
            end
        end
    end

endmodule

//--- tb_riscv_pipeline.sv
module tb_riscv_pipeline;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst;
    logic [31:0] instr = '0;
    logic [31:0] read_data = '0;
    logic [31:0] pc;
    logic        en_instr_mem;
    logic        data_we;
    logic        data_re;
    logic [31:0] data_addr;
    logic [31:0] din;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic        mem_we;
    logic        mem_re;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    int          n;
    int          cycles = 0;
    int          budget = 0;

    riscv_pipeline DUT (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .pc           (pc),
        .en_instr_mem (en_instr_mem),
        .read_data    (read_data),
        .data_we      (data_we),
        .data_re      (data_re),
        .data_addr    (data_addr),
        .din          (din)
    );

    tb_checker store_chk (
        .clk       (clk),
        .data_we   (data_we),
        .data_addr (data_addr),
        .din       (din),
        .prog      (imem),
        .mem_init  (dmem)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the fetched word holds while the enable is low
    always @(posedge clk) begin
        #2;
        if (en_instr_mem) begin
            instr <= imem[pc[9:2]];
        end
    end

    // port values sampled mid-cycle and acted on at the next rising edge
    always @(negedge clk) begin
        mem_we    = data_we;
        mem_re    = data_re;
        mem_addr  = data_addr;
        mem_wdata = din;
    end

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
        #2;
        if (mem_re) begin
            read_data <= dmem[mem_addr[9:2]];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > budget) begin
            $display("run did not finish within the limit of %0d cycles", budget);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] op_rr(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] op_ri(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_at(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_at(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_to(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                              input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_to(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] lui_of(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[n] = word;
        n++;
    endtask

    task automatic begin_program();
        budget += 20;
        @(posedge clk);
        #2;
        rst = 1'b1;
        n   = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = 32'h9E37_79B9 * (i + 1);
        end
    endtask

    // halt store followed by a jump to itself
    task automatic run_program(input string name);
        emit(sw_at(5'd0, 5'd0, 12'h3FC));
        emit(jal_to(5'd0, 21'd0));
        budget += 4 * n;
        repeat (3) @(posedge clk);
        store_chk.start_program(name);
        #2;
        rst = 1'b0;
        do begin
            @(negedge clk);
        end while (!(data_we && data_addr == 32'h0000_03FC));
        @(negedge clk);
        store_chk.end_program();
    endtask

    task automatic random_program();
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm, off;
        for (int i = 0; i < 30; i++) begin
            rd  = 5'($urandom_range(7, 0));
            rs1 = 5'($urandom_range(7, 0));
            rs2 = 5'($urandom_range(7, 0));
            imm = 12'($urandom);
            off = 12'h100 + 12'($urandom_range(31, 0) * 4);
            case ($urandom_range(11, 0))
                0:       emit(op_rr(7'h00, 3'd0, rd, rs1, rs2));
                1:       emit(op_rr(7'h20, 3'd0, rd, rs1, rs2));
                2:       emit(op_rr(7'h00, 3'd7, rd, rs1, rs2));
                3:       emit(op_rr(7'h00, 3'd6, rd, rs1, rs2));
                4:       emit(op_rr(7'h00, 3'd4, rd, rs1, rs2));
                5:       emit(op_rr(7'h00, 3'd2, rd, rs1, rs2));
                6:       emit(op_ri(3'd0, rd, rs1, imm));
                7:       emit(op_ri(3'd7, rd, rs1, imm));
                8:       emit(op_ri(3'd6, rd, rs1, imm));
                9:       emit(lw_at(rd, 5'd0, off));
                10:      emit(sw_at(rs2, 5'd0, off));
                default: emit(lui_of(rd, 20'($urandom)));
            endcase
        end
        for (int r = 0; r < 32; r++) begin
            emit(sw_at(5'(r), 5'd0, 12'h200 + 12'(r * 4)));
        end
    endtask

    initial begin
        void'($urandom(94201));
        rst = 1'b1;

        // dependent ops followed by stores that read them back
        begin_program();
        emit(lui_of(5'd1, 20'h12345));
        emit(op_ri(3'd0, 5'd2, 5'd1, 12'h678));
        emit(op_rr(7'h00, 3'd0, 5'd3, 5'd2, 5'd1));
        emit(op_rr(7'h20, 3'd0, 5'd4, 5'd3, 5'd2));
        emit(op_rr(7'h00, 3'd7, 5'd5, 5'd4, 5'd3));
        emit(op_rr(7'h00, 3'd6, 5'd6, 5'd5, 5'd2));
        emit(op_rr(7'h00, 3'd4, 5'd7, 5'd6, 5'd1));
        emit(op_rr(7'h00, 3'd2, 5'd8, 5'd7, 5'd1));
        emit(op_ri(3'd0, 5'd9, 5'd0, 12'hFFB));
        emit(op_rr(7'h00, 3'd2, 5'd10, 5'd9, 5'd0));
        emit(op_ri(3'd7, 5'd11, 5'd3, 12'h0F0));
        emit(op_ri(3'd6, 5'd12, 5'd11, 12'hF00));
        for (int r = 12; r >= 1; r--) begin
            emit(sw_at(5'(r), 5'd0, 12'h100 + 12'(r * 4)));
        end
        run_program("alu_chain");

        begin_program();
        emit(op_ri(3'd0, 5'd1, 5'd0, 12'd77));
        emit(op_ri(3'd0, 5'd2, 5'd0, 12'h123));
        emit(sw_at(5'd1, 5'd0, 12'h040));
        emit(sw_at(5'd2, 5'd0, 12'h044));
        emit(lw_at(5'd3, 5'd0, 12'h040));
        emit(lw_at(5'd4, 5'd0, 12'h044));
        emit(op_rr(7'h00, 3'd0, 5'd5, 5'd3, 5'd4));
        emit(sw_at(5'd5, 5'd0, 12'h048));
        emit(lw_at(5'd6, 5'd0, 12'h080));
        emit(op_ri(3'd0, 5'd7, 5'd6, 12'd1));
        emit(sw_at(5'd7, 5'd0, 12'h04C));
        emit(lw_at(5'd8, 5'd0, 12'h048));
        emit(sw_at(5'd8, 5'd0, 12'h050));
        run_program("load_use");

        // taken beq and bne skip two stores each
        begin_program();
        emit(op_ri(3'd0, 5'd1, 5'd0, 12'd5));
        emit(op_ri(3'd0, 5'd2, 5'd0, 12'd5));
        emit(op_ri(3'd0, 5'd3, 5'd0, 12'd9));
        emit(branch_to(3'b000, 5'd1, 5'd2, 13'd12));
        emit(sw_at(5'd1, 5'd0, 12'h060));
        emit(sw_at(5'd2, 5'd0, 12'h064));
        emit(branch_to(3'b001, 5'd1, 5'd3, 13'd12));
        emit(sw_at(5'd3, 5'd0, 12'h068));
        emit(sw_at(5'd3, 5'd0, 12'h06C));
        emit(branch_to(3'b000, 5'd1, 5'd3, 13'd8));
        emit(sw_at(5'd1, 5'd0, 12'h070));
        emit(branch_to(3'b001, 5'd1, 5'd2, 13'd8));
        emit(sw_at(5'd2, 5'd0, 12'h074));
        run_program("branches");

        begin_program();
        emit(op_ri(3'd0, 5'd1, 5'd0, 12'd3));
        emit(jal_to(5'd5, 21'd12));
        emit(op_ri(3'd0, 5'd1, 5'd0, 12'd100));
        emit(sw_at(5'd1, 5'd0, 12'h090));
        emit(sw_at(5'd5, 5'd0, 12'h094));
        emit(sw_at(5'd1, 5'd0, 12'h098));
        emit(jal_to(5'd0, 21'd8));
        emit(op_ri(3'd0, 5'd2, 5'd0, 12'd1));
        emit(sw_at(5'd2, 5'd0, 12'h09C));
        run_program("jal_link");

        begin_program();
        emit(op_ri(3'd0, 5'd0, 5'd0, 12'd55));
        emit(lui_of(5'd0, 20'hABCDE));
        emit(op_rr(7'h00, 3'd0, 5'd1, 5'd0, 5'd0));
        emit(sw_at(5'd0, 5'd0, 12'h0A0));
        emit(sw_at(5'd1, 5'd0, 12'h0A4));
        emit(op_ri(3'd0, 5'd2, 5'd0, 12'd7));
        emit(sw_at(5'd2, 5'd0, 12'h0A8));
        run_program("x0_write");

        for (int p = 0; p < 20; p++) begin
            begin_program();
            random_program();
            run_program($sformatf("random_%0d", p));
        end

        $display("stores checked: %0d, errors: %0d", store_chk.checked, store_chk.errors);
        if (store_chk.errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
